/* Makefile */
# Verilator build for the memory and writeback stages

TOP       ?= tbMemWb
VERILATOR ?= verilator
FILELIST  ?= sources.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* sources.f */
src/memStagePkg.sv
src/dataMemory.sv
src/spiMaster.sv
src/memoryCycle.sv
src/writebackCycle.sv
src/memWbTop.sv
tests/spiSlaveModel.sv
tests/tbMemWb.sv

/* src/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         we_i,
    input  logic [memStagePkg::XLEN-1:0] addr_i,
    input  logic [memStagePkg::XLEN-1:0] wdata_i,
    output logic [memStagePkg::XLEN-1:0] rdata_o
);
    import memStagePkg::*;

    localparam int IDX_W = $clog2(MEM_DEPTH);

    logic [XLEN-1:0]  mem [MEM_DEPTH];
    logic [IDX_W-1:0] wordIdx;

    // Byte address to word index, wrapping at the memory size
    assign wordIdx = addr_i[IDX_W+1:2];

    assign rdata_o = mem[wordIdx]; // Asynchronous read

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[wordIdx] <= wdata_i;
        end
    end

endmodule

/* src/memStagePkg.sv */
package memStagePkg;

    ////////////////////
    // Word widths
    ////////////////////

    localparam int XLEN         = 32; // Data and address width
    localparam int REG_ADDR_W   = 5;  // Register index width
    localparam int RESULT_SRC_W = 2;
    localparam int SPI_BYTE_W   = 8;  // Bits per SPI transfer
    localparam int SPI_SEL_W    = 4;  // Address bits that pick an SPI register

    ////////////////////
    // Result select
    ////////////////////

    // Code 3 is not decoded and falls back to the ALU result
    localparam logic [RESULT_SRC_W-1:0] RESULT_ALU = 2'd0;
    localparam logic [RESULT_SRC_W-1:0] RESULT_MEM = 2'd1;
    localparam logic [RESULT_SRC_W-1:0] RESULT_PC4 = 2'd2;

    ////////////////////
    // SPI window
    ////////////////////

    localparam logic [XLEN-1:0] SPI_BASE = 32'hFFFF_0000;

    localparam logic [SPI_SEL_W-1:0] SPI_TX_OFFSET   = 4'h0; // Write starts a transfer
    localparam logic [SPI_SEL_W-1:0] SPI_RX_OFFSET   = 4'h4; // Last received byte
    localparam logic [SPI_SEL_W-1:0] SPI_STAT_OFFSET = 4'h8; // Bit 0 is busy

endpackage

/* src/memWbTop.sv */
`timescale 1ns/1ps

module memWbTop #(
    parameter int MEM_DEPTH   = 256,
    parameter int SPI_CLK_DIV = 2
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 regWriteM_i,
    input  logic                                 memWriteM_i,
    input  logic [memStagePkg::RESULT_SRC_W-1:0] resultSrcM_i,
    input  logic [memStagePkg::REG_ADDR_W-1:0]   rdM_i,
    input  logic [memStagePkg::XLEN-1:0]         pcPlus4M_i,
    input  logic [memStagePkg::XLEN-1:0]         writeDataM_i,
    input  logic [memStagePkg::XLEN-1:0]         aluResultM_i,
    input  logic                                 misoPad_i,
    output logic                                 ssPad_o,
    output logic                                 sclkPad_o,
    output logic                                 mosiPad_o,
    output logic                                 regWrite_o,
    output logic [memStagePkg::REG_ADDR_W-1:0]   rdW_o,
    output logic [memStagePkg::XLEN-1:0]         resultW_o
);
    import memStagePkg::*;

    logic                    regWriteW;
    logic [RESULT_SRC_W-1:0] resultSrcW;
    logic [REG_ADDR_W-1:0]   rdW;
    logic [XLEN-1:0]         pcPlus4W;
    logic [XLEN-1:0]         aluResultW;
    logic [XLEN-1:0]         readDataW;

    memoryCycle #(
        .MEM_DEPTH  (MEM_DEPTH),
        .SPI_CLK_DIV(SPI_CLK_DIV)
    ) uMemoryCycle (
        .clk         (clk),
        .rst         (rst),
        .regWriteM_i (regWriteM_i),
        .memWriteM_i (memWriteM_i),
        .resultSrcM_i(resultSrcM_i),
        .rdM_i       (rdM_i),
        .pcPlus4M_i  (pcPlus4M_i),
        .writeDataM_i(writeDataM_i),
        .aluResultM_i(aluResultM_i),
        .misoPad_i   (misoPad_i),
        .ssPad_o     (ssPad_o),
        .sclkPad_o   (sclkPad_o),
        .mosiPad_o   (mosiPad_o),
        .regWriteW_o (regWriteW),
        .resultSrcW_o(resultSrcW),
        .rdW_o       (rdW),
        .pcPlus4W_o  (pcPlus4W),
        .aluResultW_o(aluResultW),
        .readDataW_o (readDataW)
    );

    writebackCycle uWritebackCycle (
        .regWriteW_i (regWriteW),
        .resultSrcW_i(resultSrcW),
        .rdW_i       (rdW),
        .pcPlus4W_i  (pcPlus4W),
        .aluResultW_i(aluResultW),
        .readDataW_i (readDataW),
        .regWrite_o  (regWrite_o),
        .rdW_o       (rdW_o),
        .resultW_o   (resultW_o)
    );

endmodule

/* src/memoryCycle.sv */
`timescale 1ns/1ps

module memoryCycle #(
    parameter int MEM_DEPTH   = 256,
    parameter int SPI_CLK_DIV = 2
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 regWriteM_i,
    input  logic                                 memWriteM_i,
    input  logic [memStagePkg::RESULT_SRC_W-1:0] resultSrcM_i,
    input  logic [memStagePkg::REG_ADDR_W-1:0]   rdM_i,
    input  logic [memStagePkg::XLEN-1:0]         pcPlus4M_i,
    input  logic [memStagePkg::XLEN-1:0]         writeDataM_i,
    input  logic [memStagePkg::XLEN-1:0]         aluResultM_i,
    input  logic                                 misoPad_i,
    output logic                                 ssPad_o,
    output logic                                 sclkPad_o,
    output logic                                 mosiPad_o,
    output logic                                 regWriteW_o,
    output logic [memStagePkg::RESULT_SRC_W-1:0] resultSrcW_o,
    output logic [memStagePkg::REG_ADDR_W-1:0]   rdW_o,
    output logic [memStagePkg::XLEN-1:0]         pcPlus4W_o,
    output logic [memStagePkg::XLEN-1:0]         aluResultW_o,
    output logic [memStagePkg::XLEN-1:0]         readDataW_o
);
    import memStagePkg::*;

    localparam logic [XLEN-1:0] SPI_FIRST = SPI_BASE + XLEN'(SPI_TX_OFFSET);
    localparam logic [XLEN-1:0] SPI_LAST  = SPI_BASE + XLEN'(SPI_STAT_OFFSET);

    logic            spiSel;
    logic            weDm;
    logic            weSpi;
    logic [XLEN-1:0] dmRdata;
    logic [XLEN-1:0] spiRdata;

    ////////////////////
    // Address decode
    ////////////////////

    assign spiSel = (aluResultM_i >= SPI_FIRST) && (aluResultM_i <= SPI_LAST);
    assign weDm   = memWriteM_i && !spiSel;
    assign weSpi  = memWriteM_i && spiSel;

    dataMemory #(
        .MEM_DEPTH(MEM_DEPTH)
    ) uDataMemory (
        .clk    (clk),
        .rst    (rst),
        .we_i   (weDm),
        .addr_i (aluResultM_i),
        .wdata_i(writeDataM_i),
        .rdata_o(dmRdata)
    );

    spiMaster #(
        .SPI_CLK_DIV(SPI_CLK_DIV)
    ) uSpiMaster (
        .clk      (clk),
        .rst      (rst),
        .we_i     (weSpi),
        .regSel_i (aluResultM_i[SPI_SEL_W-1:0]),
        .wdata_i  (writeDataM_i),
        .rdata_o  (spiRdata),
        .ssPad_o  (ssPad_o),
        .sclkPad_o(sclkPad_o),
        .mosiPad_o(mosiPad_o),
        .misoPad_i(misoPad_i)
    );

    ////////////////////
    // MEM to WB register
    ////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regWriteW_o  <= 1'b0;
            resultSrcW_o <= '0;
            rdW_o        <= '0;
            pcPlus4W_o   <= '0;
            aluResultW_o <= '0;
            readDataW_o  <= '0;
        end else begin
            regWriteW_o  <= regWriteM_i;
            resultSrcW_o <= resultSrcM_i;
            rdW_o        <= rdM_i;
            pcPlus4W_o   <= pcPlus4M_i;
            aluResultW_o <= aluResultM_i;
            readDataW_o  <= spiSel ? spiRdata : dmRdata; // Old word on a same-cycle write
        end
    end

endmodule

/* src/spiMaster.sv */
`timescale 1ns/1ps

module spiMaster #(
    parameter int SPI_CLK_DIV = 2
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              we_i,
    input  logic [memStagePkg::SPI_SEL_W-1:0] regSel_i,
    input  logic [memStagePkg::XLEN-1:0]      wdata_i,
    output logic [memStagePkg::XLEN-1:0]      rdata_o,
    output logic                              ssPad_o,
    output logic                              sclkPad_o,
    output logic                              mosiPad_o,
    input  logic                              misoPad_i
);
    import memStagePkg::*;

    localparam int EDGES  = 2 * SPI_BYTE_W; // sclk toggles per transfer
    localparam int DIV_W  = $clog2(SPI_CLK_DIV + 1);
    localparam int EDGE_W = $clog2(EDGES + 1);

    logic [SPI_BYTE_W-1:0] txReg;
    logic [SPI_BYTE_W-1:0] rxReg;
    logic [SPI_BYTE_W-1:0] shiftReg;
    logic                  busy;
    logic [DIV_W-1:0]      divCnt;
    logic [EDGE_W-1:0]     edgeCnt;
    logic                  startXfer;
    logic                  tick;
    logic                  lastEdge;

    assign startXfer = we_i && (regSel_i == SPI_TX_OFFSET) && !busy; // Ignored while busy
    assign tick      = busy && (divCnt == DIV_W'(SPI_CLK_DIV - 1));
    assign lastEdge  = tick && (edgeCnt == EDGE_W'(EDGES - 1));

    ////////////////////
    // Registers
    ////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            txReg <= '0;
        end else if (startXfer) begin
            txReg <= wdata_i[SPI_BYTE_W-1:0];
        end
    end

    always_comb begin
        rdata_o = '0;
        case (regSel_i)
            SPI_TX_OFFSET:   rdata_o = {{(XLEN - SPI_BYTE_W){1'b0}}, txReg};
            SPI_RX_OFFSET:   rdata_o = {{(XLEN - SPI_BYTE_W){1'b0}}, rxReg};
            SPI_STAT_OFFSET: rdata_o = {{(XLEN - 1){1'b0}}, busy};
            default:         rdata_o = '0;
        endcase
    end

    ////////////////////
    // Clock divider
    ////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            divCnt  <= '0;
            edgeCnt <= '0;
        end else if (startXfer) begin
            divCnt  <= '0;
            edgeCnt <= '0;
        end else if (tick) begin
            divCnt  <= '0;
            edgeCnt <= edgeCnt + 1'b1; // Counts sclk toggles
        end else if (busy) begin
            divCnt <= divCnt + 1'b1;
        end
    end

    ////////////////////
    // Shift engine
    ////////////////////

    // The MSB goes out with ss, so each rising edge samples miso and
    // leaves the next outgoing bit at the top of the shift register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy      <= 1'b0;
            ssPad_o   <= 1'b1;
            sclkPad_o <= 1'b0;
            mosiPad_o <= 1'b0;
            shiftReg  <= '0;
            rxReg     <= '0;
        end else if (startXfer) begin
            busy      <= 1'b1;
            ssPad_o   <= 1'b0;
            shiftReg  <= wdata_i[SPI_BYTE_W-1:0];
            mosiPad_o <= wdata_i[SPI_BYTE_W-1];
        end else if (tick) begin
            sclkPad_o <= ~sclkPad_o;
            if (!sclkPad_o) begin
                shiftReg <= {shiftReg[SPI_BYTE_W-2:0], misoPad_i}; // Rising edge
            end else if (lastEdge) begin
                busy      <= 1'b0;
                ssPad_o   <= 1'b1;
                mosiPad_o <= 1'b0;
                rxReg     <= shiftReg; // All eight bits are in
            end else begin
                mosiPad_o <= shiftReg[SPI_BYTE_W-1]; // Falling edge
            end
        end
    end

endmodule

/* src/writebackCycle.sv */
`timescale 1ns/1ps

module writebackCycle (
    input  logic                                 regWriteW_i,
    input  logic [memStagePkg::RESULT_SRC_W-1:0] resultSrcW_i,
    input  logic [memStagePkg::REG_ADDR_W-1:0]   rdW_i,
    input  logic [memStagePkg::XLEN-1:0]         pcPlus4W_i,
    input  logic [memStagePkg::XLEN-1:0]         aluResultW_i,
    input  logic [memStagePkg::XLEN-1:0]         readDataW_i,
    output logic                                 regWrite_o,
    output logic [memStagePkg::REG_ADDR_W-1:0]   rdW_o,
    output logic [memStagePkg::XLEN-1:0]         resultW_o
);
    import memStagePkg::*;

    always_comb begin
        case (resultSrcW_i)
            RESULT_MEM: resultW_o = readDataW_i;
            RESULT_PC4: resultW_o = pcPlus4W_i;   // Link value for jumps
            default:    resultW_o = aluResultW_i;
        endcase
    end

    // x0 is hardwired to zero, so a write to it never reaches the file
    assign regWrite_o = regWriteW_i && (rdW_i != '0);
    assign rdW_o      = rdW_i;

endmodule

/* tests/spiSlaveModel.sv */
`timescale 1ns/1ps

module spiSlaveModel (
    input  logic       ss_i,
    input  logic       sclk_i,
    input  logic       mosi_i,
    output logic       miso_o,
    output logic [7:0] rxByte_o,
    output int         xferCount_o
);
    logic [7:0] shiftIn;
    logic [7:0] shiftOut;

    initial begin
        miso_o      = 1'b0;
        rxByte_o    = 8'hA5; // Reply for the very first transfer
        xferCount_o = 0;
        shiftIn     = '0;
        shiftOut    = '0;
        forever begin
            @(negedge ss_i);
            shiftOut = rxByte_o; // Echo the byte from the previous transfer
            miso_o   = shiftOut[7];
            for (int i = 0; i < 8; i++) begin
                @(posedge sclk_i);
                shiftIn = {shiftIn[6:0], mosi_i}; // MSB arrives first
                @(negedge sclk_i);
                shiftOut = {shiftOut[6:0], 1'b0};
                miso_o   = shiftOut[7];
            end
            rxByte_o    = shiftIn;
            xferCount_o = xferCount_o + 1;
        end
    end

endmodule

/* tests/tbMemWb.sv */
`timescale 1ns/1ps

module tbMemWb;
    import memStagePkg::*;

    localparam int      MEM_DEPTH   = 256;
    localparam int      SPI_CLK_DIV = 2;
    localparam int      NUM_STORES  = 24;
    localparam int      NUM_ALU     = 24;
    localparam int      NUM_SPI     = 4;
    localparam int      XFER_CLKS   = 16 * SPI_CLK_DIV;
    localparam int      NUM_OPS     = 2 * NUM_STORES + NUM_ALU + NUM_SPI + 12;
    localparam longint  LIMIT_NS    = longint'(NUM_OPS) * (XFER_CLKS + 10) * 40;

    logic                    clk;
    logic                    rst;
    logic                    regWriteM;
    logic                    memWriteM;
    logic [RESULT_SRC_W-1:0] resultSrcM;
    logic [REG_ADDR_W-1:0]   rdM;
    logic [XLEN-1:0]         pcPlus4M;
    logic [XLEN-1:0]         writeDataM;
    logic [XLEN-1:0]         aluResultM;
    logic                    miso;
    logic                    ss;
    logic                    sclk;
    logic                    mosi;
    logic                    regWrite;
    logic [REG_ADDR_W-1:0]   rdW;
    logic [XLEN-1:0]         resultW;
    logic [7:0]              slaveByte;
    int                      slaveCount;

    logic [XLEN-1:0] sbMem [MEM_DEPTH]; // Mirror of the data memory
    logic [XLEN-1:0] storedAddr [$];
    logic [31:0]     rngState;

    memWbTop #(
        .MEM_DEPTH  (MEM_DEPTH),
        .SPI_CLK_DIV(SPI_CLK_DIV)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .regWriteM_i (regWriteM),
        .memWriteM_i (memWriteM),
        .resultSrcM_i(resultSrcM),
        .rdM_i       (rdM),
        .pcPlus4M_i  (pcPlus4M),
        .writeDataM_i(writeDataM),
        .aluResultM_i(aluResultM),
        .misoPad_i   (miso),
        .ssPad_o     (ss),
        .sclkPad_o   (sclk),
        .mosiPad_o   (mosi),
        .regWrite_o  (regWrite),
        .rdW_o       (rdW),
        .resultW_o   (resultW)
    );

    spiSlaveModel slave (
        .ss_i       (ss),
        .sclk_i     (sclk),
        .mosi_i     (mosi),
        .miso_o     (miso),
        .rxByte_o   (slaveByte),
        .xferCount_o(slaveCount)
    );

    always #20 clk = ~clk;

    task automatic reportMismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "check failed");
    endtask

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic int wordIndex(input logic [XLEN-1:0] addr);
        return int'((addr >> 2) % MEM_DEPTH);
    endfunction

    // Random word address outside the SPI window
    function automatic logic [XLEN-1:0] memAddress();
        logic [XLEN-1:0] addr;
        addr = nextRandom() & 32'hFFFF_FFFC;
        if (addr >= SPI_BASE && addr <= SPI_BASE + 32'd8) begin
            addr = addr ^ 32'h8000_0000;
        end
        return addr;
    endfunction

    ////////////////////
    // Pads and reset
    ////////////////////

    assert property (@(posedge clk) !rst |-> (ss && !sclk && !mosi && !regWrite))
        else reportMismatch("outputs not at reset values");
    assert property (@(posedge clk) disable iff (!rst) !(regWrite && rdW == '0))
        else reportMismatch("register write to x0");
    assert property (@(posedge clk) disable iff (!rst) ss |-> !sclk)
        else reportMismatch("sclk active with ss high");

    // Called 2 ns after an edge, returns 2 ns after the edge that registers the op
    task automatic issueOp(input logic rw, input logic mw, input logic [1:0] src,
                           input logic [4:0] rd, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] pc4);
        regWriteM  = rw;
        memWriteM  = mw;
        resultSrcM = src;
        rdM        = rd;
        aluResultM = addr;
        writeDataM = wdata;
        pcPlus4M   = pc4;
        @(posedge clk);
        #2;
        memWriteM = 1'b0;
    endtask

    task automatic loadCheck(input logic [31:0] addr, input logic [31:0] expected);
        logic [4:0] rd;
        rd = 5'(nextRandom() % 31 + 1);
        issueOp(1'b1, 1'b0, RESULT_MEM, rd, addr, '0, '0);
        assert (resultW == expected && regWrite && rdW == rd)
            else reportMismatch($sformatf("load %h got %h expected %h", addr, resultW, expected));
    endtask

    task automatic aluCheck(input logic [1:0] src);
        logic [31:0] alu;
        logic [31:0] pc4;
        logic [4:0]  rd;
        logic        rw;
        alu = nextRandom();
        pc4 = nextRandom() & 32'hFFFF_FFFC;
        rd  = (nextRandom() % 4 == 0) ? 5'd0 : 5'(nextRandom());
        rw  = nextRandom() % 3 != 0;
        issueOp(rw, 1'b0, src, rd, alu, '0, pc4);
        assert (resultW == ((src == RESULT_PC4) ? pc4 : alu))
            else reportMismatch($sformatf("src %0d result %h", src, resultW));
        assert (regWrite == (rw && rd != 5'd0))
            else reportMismatch($sformatf("regWrite %b for rd %0d", regWrite, rd));
    endtask

    task automatic spiTransfer(input logic [7:0] txByte, input logic [7:0] expReply);
        int count;
        count = slaveCount;
        issueOp(1'b0, 1'b1, RESULT_ALU, 5'd0, SPI_BASE, {24'(nextRandom()), txByte}, '0);
        for (int k = 0; k <= XFER_CLKS; k++) begin
            assert (ss == (k == XFER_CLKS))
                else reportMismatch($sformatf("ss %b at clock %0d of transfer", ss, k));
            loadCheck(SPI_BASE + 32'd8, {31'b0, k < XFER_CLKS});
        end
        assert (slaveByte == txByte && slaveCount == count + 1)
            else reportMismatch($sformatf("slave got %h expected %h", slaveByte, txByte));
        loadCheck(SPI_BASE + 32'd4, {24'b0, expReply});
    endtask

    initial begin
        #(LIMIT_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [7:0]  txByte;
        logic [7:0]  reply;
        clk        = 1'b0;
        rst        = 1'b1;
        regWriteM  = 1'b0;
        memWriteM  = 1'b0;
        resultSrcM = '0;
        rdM        = '0;
        pcPlus4M   = '0;
        writeDataM = '0;
        aluResultM = '0;
        rngState   = 32'd2;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            sbMem[i] = '0;
        end
        #1;
        rst = 1'b0; // Falling edge applies the asynchronous reset at once
        repeat (10) begin
            @(posedge clk);
            #2;
            assert (!regWrite && ss && !sclk && !mosi) else reportMismatch("reset state");
        end
        rst = 1'b1;
        @(posedge clk);
        #2;
        assert (!regWrite && ss) else reportMismatch("state after reset");

        for (int i = 0; i < NUM_STORES; i++) begin
            addr = memAddress();
            data = nextRandom();
            issueOp(1'b0, 1'b1, RESULT_ALU, 5'(i), addr, data, '0);
            sbMem[wordIndex(addr)] = data;
            storedAddr.push_back(addr);
        end
        foreach (storedAddr[i]) begin
            loadCheck(storedAddr[i], sbMem[wordIndex(storedAddr[i])]);
        end

        for (int i = 0; i < NUM_ALU; i++) begin
            aluCheck((i % 3 == 0) ? RESULT_ALU : ((i % 3 == 1) ? RESULT_PC4 : 2'd3));
        end

        reply = 8'hA5;
        for (int i = 0; i < NUM_SPI; i++) begin
            txByte = 8'(nextRandom());
            spiTransfer(txByte, reply);
            reply = txByte; // The slave echoes what it just received
        end
        // Writes to the other SPI registers start nothing
        issueOp(1'b0, 1'b1, RESULT_ALU, 5'd0, SPI_BASE + 32'd4, nextRandom(), '0);
        issueOp(1'b0, 1'b1, RESULT_ALU, 5'd0, SPI_BASE + 32'd8, nextRandom(), '0);
        assert (ss) else reportMismatch("transfer started by a non-transmit write");

        // The SPI registers share their index bits with data-memory words 0 to 2
        for (int i = 0; i < 3; i++) begin
            addr = (SPI_BASE + 32'(4 * i)) ^ 32'h8000_0000;
            loadCheck(addr, sbMem[wordIndex(addr)]);
        end

        foreach (storedAddr[i]) begin
            loadCheck(storedAddr[i], sbMem[wordIndex(storedAddr[i])]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule
